//--- obj_line_pkg.sv
// shared constants for the sprite line renderer; sprite RAM words are 16 bits, four per sprite
package obj_line_pkg;

    localparam int NUM_SPRITES = 256;    // sprites scanned per line
    localparam int NUM_LEVELS  = 16;     // priority levels
    localparam int QUEUE_DEPTH = 256;    // entries per level, power of two
    localparam int LINE_WIDTH  = 320;    // visible pixels
    localparam int RAM_AW      = 13;     // sprite RAM word address width

    // attribute word layout
    localparam int ATTR_ACTIVE_BIT = 15; // word 0
    localparam int ATTR_XFLIP_BIT  = 12; // word 0
    localparam int ATTR_PRI_LSB    = 8;  // word 0, 4 bits
    localparam int ATTR_PAL_LSB    = 2;  // word 0, 6 bits
    localparam int ATTR_POS_LSB    = 7;  // words 2 and 3, 9 bits
    localparam int ATTR_SIZE_LSB   = 0;  // words 2 and 3, 4 bits

    localparam int TILE_ROW_BYTES = 32;  // offset step per tile

    // pixel word: priority 15:12, palette 9:4, code 3:0
    localparam int PIX_W = 16;

endpackage

//--- obj_line_if.sv
// sprite RAM request and queue pop buses; RAM data is valid one cycle after grant
interface obj_ram_if #(
    parameter int AW = 13
);
    logic          req;
    logic [AW-1:0] addr_a;   // base word of the pair
    logic [AW-1:0] addr_b;   // second word, offset chosen by requester
    logic          gnt;
    logic [15:0]   rdata_a;
    logic [15:0]   rdata_b;
    logic          rvalid;

    modport requester (
        output req, addr_a, addr_b,
        input  gnt, rdata_a, rdata_b, rvalid
    );

    modport arbiter (
        input  req, addr_a, addr_b,
        output gnt, rdata_a, rdata_b, rvalid
    );
endinterface

interface obj_queue_if #(
    parameter int IW = 8
);
    logic          pop;
    logic [IW-1:0] index;
    logic          index_valid;  // one cycle after pop
    logic          empty;

    modport queue (
        input  pop,
        output index, index_valid, empty
    );

    modport drawer (
        output pop,
        input  index, index_valid, empty
    );
endinterface

//--- obj_ram_arbiter.sv
// fixed priority, drawer wins a tie; only one requester may own the RAM pair per cycle
module obj_ram_arbiter import obj_line_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    obj_ram_if.arbiter        scan_bus,
    obj_ram_if.arbiter        draw_bus,
    output logic [RAM_AW-1:0] spr_ram_addr_a_o,
    output logic [RAM_AW-1:0] spr_ram_addr_b_o,
    input  logic [15:0]       spr_ram_data_a_i,
    input  logic [15:0]       spr_ram_data_b_i
);

    logic scan_own_q;   // owner of the read now returning
    logic draw_own_q;

    assign draw_bus.gnt = draw_bus.req;
    assign scan_bus.gnt = scan_bus.req & ~draw_bus.req;

    assign spr_ram_addr_a_o = draw_bus.req ? draw_bus.addr_a : scan_bus.addr_a;
    assign spr_ram_addr_b_o = draw_bus.req ? draw_bus.addr_b : scan_bus.addr_b;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            scan_own_q <= 1'b0;
            draw_own_q <= 1'b0;
        end else begin
            scan_own_q <= scan_bus.gnt;
            draw_own_q <= draw_bus.gnt;
        end
    end

    assign scan_bus.rvalid  = scan_own_q;
    assign draw_bus.rvalid  = draw_own_q;
    assign scan_bus.rdata_a = spr_ram_data_a_i;
    assign scan_bus.rdata_b = spr_ram_data_b_i;
    assign draw_bus.rdata_a = spr_ram_data_a_i;
    assign draw_bus.rdata_b = spr_ram_data_b_i;

endmodule

//--- obj_line_scanner.sv
// y visibility only: no wrap-around at 512 and no clipping at the top of the screen
module obj_line_scanner import obj_line_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           line_start_i,
    input  logic [8:0]                     vrender_i,
    input  logic [8:0]                     scroll_y_i,
    input  logic                           busy_i,
    obj_ram_if.requester                   ram,
    output logic                           q_clear_o,
    output logic                           q_push_o,
    output logic [$clog2(NUM_LEVELS)-1:0]  q_push_level_o,
    output logic [$clog2(NUM_SPRITES)-1:0] q_push_index_o,
    output logic                           scan_busy_o,
    output logic                           scan_done_o
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;
    localparam logic [1:0] S_DONE = 2'd3;

    logic [1:0]                     state;
    logic [$clog2(NUM_SPRITES)-1:0] spr;
    logic                           start_ok;
    logic [8:0]                     spr_y;
    logic [4:0]                     rows;     // height in tiles
    logic [9:0]                     y_end;
    logic                           visible;

    assign start_ok = line_start_i && (state == S_IDLE) && !busy_i;

    // word 0 on port A, word 3 on port B
    assign ram.req    = (state == S_REQ);
    assign ram.addr_a = RAM_AW'({spr, 2'b00});
    assign ram.addr_b = ram.addr_a + RAM_AW'(3);

    assign spr_y   = ram.rdata_b[ATTR_POS_LSB +: 9] + scroll_y_i;
    assign rows    = ram.rdata_b[ATTR_SIZE_LSB +: 4] + 5'd1;
    assign y_end   = {1'b0, spr_y} + {2'b00, rows, 3'b000};
    assign visible = (vrender_i >= spr_y) && ({1'b0, vrender_i} < y_end);

    assign q_clear_o      = start_ok;
    assign q_push_o       = (state == S_DATA) && ram.rvalid
                            && ram.rdata_a[ATTR_ACTIVE_BIT] && visible;
    assign q_push_level_o = ram.rdata_a[ATTR_PRI_LSB +: 4];
    assign q_push_index_o = spr;

    assign scan_busy_o = (state != S_IDLE);
    assign scan_done_o = (state == S_DONE);  // one cycle, after the last push

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= S_IDLE;
            spr   <= '0;
        end else begin
            case (state)
                S_IDLE: if (start_ok) begin
                    spr   <= '0;
                    state <= S_REQ;
                end
                S_REQ: if (ram.gnt) state <= S_DATA;
                S_DATA: if (ram.rvalid) begin
                    if (spr == $clog2(NUM_SPRITES)'(NUM_SPRITES - 1)) begin
                        state <= S_DONE;
                    end else begin
                        spr   <= spr + 1'b1;
                        state <= S_REQ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- obj_pri_queue.sv
// LEVELS must be a power of two; no push while pops are in progress on the same level
module obj_pri_queue import obj_line_pkg::*; #(
    parameter int LEVELS = NUM_LEVELS
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           clear_i,
    input  logic                           push_i,
    input  logic [$clog2(LEVELS)-1:0]      push_level_i,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] push_index_i,
    obj_queue_if.queue                     pop_bus
);

    localparam int LW = $clog2(LEVELS);
    localparam int IW = $clog2(QUEUE_DEPTH);
    localparam int CW = IW + 1;  // a full level holds QUEUE_DEPTH

    logic [IW-1:0]             mem [LEVELS*QUEUE_DEPTH];
    logic [LEVELS-1:0][CW-1:0] push_cnt;
    logic [LEVELS-1:0][CW-1:0] pop_cnt;
    logic [LEVELS-1:0]         occupied;
    logic [LW-1:0]             low_lvl;

    // lowest occupied level
    always_comb begin
        low_lvl = '0;
        for (int l = LEVELS - 1; l >= 0; l--) begin
            if (occupied[l]) low_lvl = LW'(l);
        end
    end

    assign pop_bus.empty = ~|occupied;

    always_ff @(posedge clk_i) begin
        if (push_i) mem[{push_level_i, push_cnt[push_level_i][IW-1:0]}] <= push_index_i;
        if (pop_bus.pop) pop_bus.index <= mem[{low_lvl, pop_cnt[low_lvl][IW-1:0]}];
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            push_cnt            <= '0;
            pop_cnt             <= '0;
            occupied            <= '0;
            pop_bus.index_valid <= 1'b0;
        end else if (clear_i) begin
            push_cnt            <= '0;
            pop_cnt             <= '0;
            occupied            <= '0;
            pop_bus.index_valid <= 1'b0;
        end else begin
            pop_bus.index_valid <= pop_bus.pop;
            if (pop_bus.pop) begin
                pop_cnt[low_lvl] <= pop_cnt[low_lvl] + 1'b1;
                if (pop_cnt[low_lvl] + 1'b1 == push_cnt[low_lvl]) occupied[low_lvl] <= 1'b0;
            end
            if (push_i) begin                         // after the pop so a set wins
                push_cnt[push_level_i] <= push_cnt[push_level_i] + 1'b1;
                occupied[push_level_i] <= 1'b1;
            end
        end
    end

endmodule

//--- obj_tile_drawer.sv
// no vertical flip or chaining; pixels past LINE_W are dropped, x does not wrap
module obj_tile_drawer import obj_line_pkg::*; #(
    parameter int LINE_W = LINE_WIDTH
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      scan_done_i,
    input  logic [8:0]                vrender_i,
    input  logic [8:0]                scroll_x_i,
    input  logic [8:0]                scroll_y_i,
    obj_ram_if.requester              ram,
    obj_queue_if.drawer               pop_bus,
    output logic                      gfx_cs_o,
    output logic [14:0]               tile_number_o,
    output logic [15:0]               tile_offs_o,
    output logic [2:0]                tile_bank_o,
    input  logic                      gfx_ok_i,
    input  logic [31:0]               gfx_data_i,
    output logic                      wr_en_o,
    output logic [$clog2(LINE_W)-1:0] wr_addr_o,
    output logic [PIX_W-1:0]          wr_data_o,
    output logic                      draw_busy_o
);

    localparam logic [3:0] S_IDLE  = 4'd0;
    localparam logic [3:0] S_NEXT  = 4'd1;
    localparam logic [3:0] S_INDEX = 4'd2;
    localparam logic [3:0] S_REQ01 = 4'd3;
    localparam logic [3:0] S_REQ23 = 4'd4;
    localparam logic [3:0] S_ATTR  = 4'd5;
    localparam logic [3:0] S_TILE  = 4'd6;
    localparam logic [3:0] S_GFX   = 4'd7;
    localparam logic [3:0] S_DRAW  = 4'd8;

    logic [3:0]  state;
    logic [3:0]  col;        // tile column within the sprite
    logic [2:0]  px;         // pixel within the tile
    logic [7:0]  spr_idx;
    logic [15:0] w0, w1, w2, w3;
    logic [31:0] gfx_word;
    logic [RAM_AW-1:0] base;
    logic [8:0]  spr_x, spr_y, row;
    logic [3:0]  xsize;
    logic [6:0]  p;
    logic [9:0]  x_pos;
    logic [3:0]  code;
    logic [15:0] offs;

    assign base       = RAM_AW'({spr_idx, 2'b00});
    assign ram.req    = (state == S_REQ01) || (state == S_REQ23);
    assign ram.addr_a = (state == S_REQ23) ? base + RAM_AW'(2) : base;
    assign ram.addr_b = ram.addr_a + RAM_AW'(1);

    assign pop_bus.pop = (state == S_NEXT) && !pop_bus.empty;
    assign draw_busy_o = (state != S_IDLE);

    assign spr_x = w2[ATTR_POS_LSB +: 9] + scroll_x_i;
    assign spr_y = w3[ATTR_POS_LSB +: 9] + scroll_y_i;
    assign row   = vrender_i - spr_y;
    assign xsize = w2[ATTR_SIZE_LSB +: 4];
    assign p     = {col, px};
    assign x_pos = w0[ATTR_XFLIP_BIT] ? {1'b0, spr_x} + {3'b000, xsize, 3'b111} - {3'b000, p}
                                      : {1'b0, spr_x} + {3'b000, p};

    // tile rows above, then line within the tile, then column
    assign offs = 16'(row[8:3]) * (16'(xsize) + 16'd1) * 16'(TILE_ROW_BYTES)
                + 16'({row[2:0], 2'b00})
                + 16'(col) * 16'(TILE_ROW_BYTES);

    assign code      = gfx_word[{px, 2'b00} +: 4];  // nibble 0 is leftmost
    assign wr_en_o   = (state == S_DRAW) && (code != 4'd0) && (x_pos < LINE_W);
    assign wr_addr_o = x_pos[$clog2(LINE_W)-1:0];
    assign wr_data_o = {w0[ATTR_PRI_LSB +: 4], 2'b00, w0[ATTR_PAL_LSB +: 6], code};

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state    <= S_IDLE;
            gfx_cs_o <= 1'b0;
            col      <= '0;
            px       <= '0;
        end else begin
            case (state)
                S_IDLE:  if (scan_done_i) state <= S_NEXT;
                S_NEXT:  state <= pop_bus.empty ? S_IDLE : S_INDEX;
                S_INDEX: if (pop_bus.index_valid) state <= S_REQ01;
                S_REQ01: if (ram.gnt) state <= S_REQ23;
                S_REQ23: if (ram.gnt) state <= S_ATTR;
                S_ATTR: if (ram.rvalid) begin
                    col   <= '0;
                    state <= S_TILE;
                end
                S_TILE: begin
                    gfx_cs_o <= 1'b1;
                    state    <= S_GFX;
                end
                S_GFX: if (gfx_ok_i) begin
                    gfx_cs_o <= 1'b0;
                    px       <= '0;
                    state    <= S_DRAW;
                end
                S_DRAW: begin
                    px <= px + 1'b1;
                    if (px == 3'd7) begin
                        if (col == xsize) begin
                            state <= S_NEXT;
                        end else begin
                            col   <= col + 1'b1;
                            state <= S_TILE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == S_INDEX && pop_bus.index_valid) spr_idx <= pop_bus.index;
        if (state == S_REQ23 && ram.rvalid) begin   // words 0 and 1
            w0 <= ram.rdata_a;
            w1 <= ram.rdata_b;
        end
        if (state == S_ATTR && ram.rvalid) begin
            w2 <= ram.rdata_a;
            w3 <= ram.rdata_b;
        end
        if (state == S_TILE) begin                   // held stable until gfx_ok_i
            tile_number_o <= w1[14:0];
            tile_offs_o   <= offs;
            tile_bank_o   <= {w0[1:0], w1[15]};
        end
        if (state == S_GFX && gfx_ok_i) gfx_word <= gfx_data_i;
    end

endmodule

//--- obj_line_buffer.sv
// both banks take LINE_W cycles to clear after reset; reads at h_i beyond LINE_W give zero
module obj_line_buffer import obj_line_pkg::*; #(
    parameter int LINE_W = LINE_WIDTH
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      swap_i,
    input  logic                      wr_en_i,
    input  logic [$clog2(LINE_W)-1:0] wr_addr_i,
    input  logic [PIX_W-1:0]          wr_data_i,
    input  logic [8:0]                h_i,
    input  logic                      pixel_cen_i,
    output logic [PIX_W-1:0]          pixel_o
);

    localparam int AW = $clog2(LINE_W);

    logic [PIX_W-1:0] mem [2][LINE_W];
    logic             wr_bank;    // bank being drawn, the other one is read
    logic             init_clr;
    logic [AW-1:0]    clr_addr;
    logic             rd_ok;

    assign rd_ok = pixel_cen_i && (h_i < LINE_W);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_bank  <= 1'b0;
            init_clr <= 1'b1;
            clr_addr <= '0;
            pixel_o  <= '0;
        end else begin
            if (swap_i) wr_bank <= ~wr_bank;
            if (init_clr) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == AW'(LINE_W - 1)) init_clr <= 1'b0;
            end
            if (pixel_cen_i) pixel_o <= rd_ok ? mem[~wr_bank][h_i[AW-1:0]] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (init_clr) begin
            mem[0][clr_addr] <= '0;
            mem[1][clr_addr] <= '0;
        end else begin
            if (wr_en_i) mem[wr_bank][wr_addr_i] <= wr_data_i;
            if (rd_ok) mem[~wr_bank][h_i[AW-1:0]] <= '0;  // clean for the next draw
        end
    end

endmodule

//--- obj_line_top.sv
// sprite RAM reads have one cycle latency; gfx_cs_o is held until gfx_ok_i
module obj_line_top import obj_line_pkg::*; #(
    parameter int LINE_W = LINE_WIDTH,
    parameter int LEVELS = NUM_LEVELS
) (
    input  logic              CLK96,
    input  logic              RESET96,
    input  logic              line_start_i,
    input  logic [8:0]        vrender_i,
    input  logic [8:0]        scroll_x_i,
    input  logic [8:0]        scroll_y_i,
    input  logic [8:0]        h_i,
    input  logic              pixel_cen_i,
    output logic [RAM_AW-1:0] spr_ram_addr_a_o,
    output logic [RAM_AW-1:0] spr_ram_addr_b_o,
    input  logic [15:0]       spr_ram_data_a_i,
    input  logic [15:0]       spr_ram_data_b_i,
    output logic              gfx_cs_o,
    output logic [14:0]       tile_number_o,
    output logic [15:0]       tile_offs_o,
    output logic [2:0]        tile_bank_o,
    input  logic              gfx_ok_i,
    input  logic [31:0]       gfx_data_i,
    output logic [PIX_W-1:0]  pixel_o,
    output logic              busy_o
);

    logic                           q_clear;
    logic                           q_push;
    logic [$clog2(LEVELS)-1:0]      q_push_level;
    logic [$clog2(QUEUE_DEPTH)-1:0] q_push_index;
    logic                           scan_busy;
    logic                           scan_done;
    logic                           draw_busy;
    logic                           wr_en;
    logic [$clog2(LINE_W)-1:0]      wr_addr;
    logic [PIX_W-1:0]               wr_data;

    obj_ram_if #(.AW(RAM_AW)) scan_ram ();
    obj_ram_if #(.AW(RAM_AW)) draw_ram ();
    obj_queue_if #(.IW($clog2(QUEUE_DEPTH))) pop_bus ();

    assign busy_o = scan_busy | draw_busy;

    obj_ram_arbiter i_obj_ram_arbiter (
        .clk_i(CLK96), .rst_i(RESET96), .scan_bus(scan_ram), .draw_bus(draw_ram),
        .spr_ram_addr_a_o, .spr_ram_addr_b_o, .spr_ram_data_a_i, .spr_ram_data_b_i
    );

    obj_line_scanner i_obj_line_scanner (
        .clk_i(CLK96), .rst_i(RESET96), .line_start_i, .vrender_i, .scroll_y_i,
        .busy_i(draw_busy), .ram(scan_ram), .q_clear_o(q_clear), .q_push_o(q_push),
        .q_push_level_o(q_push_level), .q_push_index_o(q_push_index),
        .scan_busy_o(scan_busy), .scan_done_o(scan_done)
    );

    obj_pri_queue #(.LEVELS(LEVELS)) i_obj_pri_queue (
        .clk_i(CLK96), .rst_i(RESET96), .clear_i(q_clear), .push_i(q_push),
        .push_level_i(q_push_level), .push_index_i(q_push_index), .pop_bus(pop_bus)
    );

    obj_tile_drawer #(.LINE_W(LINE_W)) i_obj_tile_drawer (
        .clk_i(CLK96), .rst_i(RESET96), .scan_done_i(scan_done), .vrender_i,
        .scroll_x_i, .scroll_y_i, .ram(draw_ram), .pop_bus(pop_bus),
        .gfx_cs_o, .tile_number_o, .tile_offs_o, .tile_bank_o, .gfx_ok_i, .gfx_data_i,
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .draw_busy_o(draw_busy)
    );

    obj_line_buffer #(.LINE_W(LINE_W)) i_obj_line_buffer (
        .clk_i(CLK96), .rst_i(RESET96), .swap_i(line_start_i), .wr_en_i(wr_en),
        .wr_addr_i(wr_addr), .wr_data_i(wr_data), .h_i, .pixel_cen_i, .pixel_o
    );

endmodule

//--- obj_line_assertions.sv
// protocol checks bound into obj_line_top; gnt signals are read straight from the RAM buses
module obj_line_assertions #(
    parameter int LINE_W = 320
) (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      busy_i,
    input logic                      gfx_cs_i,
    input logic                      gfx_ok_i,
    input logic [33:0]               tile_i,     // bank, number and offset
    input logic                      wr_en_i,
    input logic [$clog2(LINE_W)-1:0] wr_addr_i,
    input logic                      scan_gnt_i,
    input logic                      draw_gnt_i
);
    timeunit 1ns;
    timeprecision 1ps;

    a_gfx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        gfx_cs_i && !gfx_ok_i |=> gfx_cs_i && $stable(tile_i))
        else $error("gfx_cs_o or tile outputs changed before gfx_ok_i");

    a_idle_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> !busy_i)
        else $error("busy_o high right after reset");

    a_wr_range: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_i |-> wr_addr_i < LINE_W)
        else $error("line buffer write beyond the line width");

    a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(scan_gnt_i && draw_gnt_i))
        else $error("both RAM requesters granted together");

endmodule

bind obj_line_top obj_line_assertions #(.LINE_W(LINE_W)) i_obj_line_assertions (
    .clk_i(CLK96), .rst_i(RESET96), .busy_i(busy_o), .gfx_cs_i(gfx_cs_o),
    .gfx_ok_i(gfx_ok_i), .tile_i({tile_bank_o, tile_number_o, tile_offs_o}),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr),
    .scan_gnt_i(scan_ram.gnt), .draw_gnt_i(draw_ram.gnt)
);

//--- obj_line_tb.sv
// stimulus and expected values come from obj_line_trace.txt in the run directory
module obj_line_tb import obj_line_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    logic              CLK96 = 1'b0;
    logic              RESET96;
    logic              line_start_i;
    logic [8:0]        vrender_i, scroll_x_i, scroll_y_i, h_i;
    logic              pixel_cen_i;
    logic [RAM_AW-1:0] spr_ram_addr_a_o, spr_ram_addr_b_o;
    logic [15:0]       spr_ram_data_a_i, spr_ram_data_b_i;
    logic              gfx_cs_o, gfx_ok_i;
    logic [14:0]       tile_number_o;
    logic [15:0]       tile_offs_o;
    logic [2:0]        tile_bank_o;
    logic [31:0]       gfx_data_i;
    logic [PIX_W-1:0]  pixel_o;
    logic              busy_o;

    logic [35:0]       trace [16384];   // sprite RAM at 0, graphics at 2000, lines at 2100
    logic [35:0]       req_log [$];
    logic [15:0]       exp_pix [LINE_WIDTH];
    logic [RAM_AW-1:0] addr_a_q = '0;
    logic [RAM_AW-1:0] addr_b_q = '0;
    logic              capture = 1'b0;
    logic              gfx_pending = 1'b0;
    int                gfx_wait;
    int                seed = 83892;
    int                errors = 0;
    int                cycles = 0;
    int                cycle_limit = 6000;
    int                ptr;

    always #4 CLK96 = ~CLK96;

    obj_line_top i_obj_line_top (.*);

    // sprite RAM with one cycle of latency
    always @(negedge CLK96) begin
        spr_ram_data_a_i = trace[addr_a_q][15:0];
        spr_ram_data_b_i = trace[addr_b_q][15:0];
        addr_a_q         = spr_ram_addr_a_o;
        addr_b_q         = spr_ram_addr_b_o;
    end

    function automatic logic [31:0] gfx_lookup(input logic [14:0] tile, input logic [15:0] offs);
        logic [31:0] result;
        int          k;
        result = '0;
        for (k = 'h2000; k < 'h2100 && trace[k] != 36'hFFFFFFFFF; k += 2) begin
            if (trace[k] == {5'd0, tile, offs}) result = trace[k+1][31:0];
        end
        return result;
    endfunction

    // graphics ROM that answers after 0 to 5 cycles
    always @(negedge CLK96) begin
        if (gfx_ok_i) begin
            gfx_ok_i    = 1'b0;
            gfx_pending = 1'b0;
        end else if (gfx_cs_o) begin
            if (!gfx_pending) begin
                gfx_pending = 1'b1;
                gfx_wait    = $unsigned($random(seed)) % 6;
            end
            if (gfx_wait == 0) begin
                gfx_ok_i   = 1'b1;
                gfx_data_i = gfx_lookup(tile_number_o, tile_offs_o);
            end else begin
                gfx_wait--;
            end
        end
    end

    always @(posedge CLK96) begin
        if (capture && gfx_cs_o && gfx_ok_i)
            req_log.push_back({2'b00, tile_bank_o, tile_number_o, tile_offs_o});
    end

    always @(posedge CLK96) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check(input logic [35:0] actual, input logic [35:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic run_line(inout int p);
        int          npix;
        int          nreq;
        logic [35:0] ent;
        while (busy_o) @(negedge CLK96);
        vrender_i  = trace[p][8:0];
        scroll_x_i = trace[p+1][8:0];
        scroll_y_i = trace[p+2][8:0];
        npix       = int'(trace[p+3]);
        nreq       = int'(trace[p+4]);
        p += 5;
        foreach (exp_pix[i]) exp_pix[i] = '0;
        for (int i = 0; i < npix; i++) begin
            ent = trace[p+i];
            exp_pix[ent[24:16]] = ent[15:0];    // x above the pixel word
        end
        p += npix;
        req_log.delete();
        capture      = 1'b1;
        line_start_i = 1'b1;
        @(negedge CLK96);
        line_start_i = 1'b0;
        @(negedge CLK96);
        while (busy_o) @(negedge CLK96);
        capture = 1'b0;
        check(36'(req_log.size()), 36'(nreq), "graphics request count");
        for (int i = 0; i < nreq && i < req_log.size(); i++)
            check(req_log[i], trace[p+i], $sformatf("graphics request %0d", i));
        p += nreq;
        line_start_i = 1'b1;    // swap so the drawn bank goes to the read side
        @(negedge CLK96);
        line_start_i = 1'b0;
        for (int x = 0; x < LINE_WIDTH; x++) begin
            h_i         = 9'(x);
            pixel_cen_i = 1'b1;
            @(negedge CLK96);
            check(36'(pixel_o), 36'(exp_pix[x]), $sformatf("pixel %0d", x));
        end
        pixel_cen_i = 1'b0;
    endtask

    initial begin
        foreach (trace[i]) trace[i] = '0;
        $readmemh("obj_line_trace.txt", trace);
        cycle_limit      = int'(trace['h2100]) * 6000;
        RESET96          = 1'b1;
        line_start_i     = 1'b0;
        vrender_i        = '0;
        scroll_x_i       = '0;
        scroll_y_i       = '0;
        h_i              = '0;
        pixel_cen_i      = 1'b0;
        spr_ram_data_a_i = '0;
        spr_ram_data_b_i = '0;
        gfx_ok_i         = 1'b0;
        gfx_data_i       = '0;
        repeat (3) @(negedge CLK96);
        RESET96 = 1'b0;
        @(negedge CLK96);
        check(36'(busy_o), 36'd0, "busy_o after reset");
        check(36'(gfx_cs_o), 36'd0, "gfx_cs_o after reset");
        ptr = 'h2101;
        for (int n = 0; n < int'(trace['h2100]); n++) run_line(ptr);
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- obj_line_trace.txt
// @0000 sprite RAM: words 0..3 per sprite; @2000 graphics pairs {tile,offs} data, ends at FFFFFFFFF
// @2100 line count, then per line: vrender scroll_x scroll_y npix nreq, {x,pixel}..., {bank,tile,offs}...
@0000 8000 0000 0000 6400
@0004 0314 0000 0000 3000
@0008 8314 0010 0500 0A00
@000C 8108 0011 0600 0900
@0010 8204 0012 3200 0B00
@0014 820E 8013 3400 0B00
@0018 9428 0020 9601 0F01
@001C 8504 0021 9E00 1400
@2000
00100008 87654301
00110010 22222222
00120000 11111111
00130000 00009999
00200050 00000021
00200070 50000003
00210008 FFFFFFFF
FFFFFFFFF 0
@2100 3
// line 1: one sprite off the line, one inactive
064 000 000 0 0
// line 2: overlap across levels and within level 2
016 005 000 11 4
0F3051 113053 123054 133055 143056 153057 163058 171022 181022
692011 6A2011 6B2011 6C2011 6D2039 6E2039 6F2039 702039
000110010 000120000 280130000 000100008
// line 3: xflip over two columns, clipping at 320
02D 000 003 8 3
12C40A5 13340A3 13A40A2 13B40A1 13C501F 13D501F 13E501F 13F501F
000200050 000200070 000210008

//--- obj_line_top.f
obj_line_pkg.sv
obj_line_if.sv
obj_ram_arbiter.sv
obj_line_scanner.sv
obj_pri_queue.sv
obj_tile_drawer.sv
obj_line_buffer.sv
obj_line_top.sv
obj_line_assertions.sv
obj_line_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite line renderer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f obj_line_top.f --top-module obj_line_tb -o obj_line_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/obj_line_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with an error status"
    exit 1
fi

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1
